/* test/execute_testdata.txt */
# op rs1 rs2 rd v1 v2 imm alu_rd mm_rd wb_rd alu_res mdata mm_alu wb alu_ld mm_ld br
# then expected: stall result rs2_out rd_out update_rd mm_load (all hex)
01 01 02 03 5 7 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 c 7 03 1 0
02 01 02 03 5 7 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 fffffffffffffffe 7 03 1 0
03 01 02 03 1 3f 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 8000000000000000 3f 03 1 0
04 01 02 03 ffffffffffffffff 1 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 1 1 03 1 0
05 01 02 03 ffffffffffffffff 1 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 0 1 03 1 0
06 01 02 03 f0 ff 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 f ff 03 1 0
07 01 02 03 8000000000000000 3f 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 1 3f 03 1 0
08 01 02 03 8000000000000000 3c 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 fffffffffffffff8 3c 03 1 0
09 01 02 03 f0 0f 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 ff f 03 1 0
0a 01 02 03 f0 3c 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 30 3c 03 1 0
0b 01 02 03 10 2 fffffffffffffff0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 0 2 03 1 0
0c 01 02 03 fffffffffffffffe 2 ffffffffffffffff 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 1 2 03 1 0
0d 01 02 03 5 2 ffffffffffffffff 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 1 2 03 1 0
0e 01 02 03 ff 2 ffffffffffffffff 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 ffffffffffffff00 2 03 1 0
0f 01 02 03 100 2 1 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 101 2 03 1 0
10 01 02 03 ffff 2 ff0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 ff0 2 03 1 0
11 01 02 03 3 2 4 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 30 2 03 1 0
12 01 02 03 ff00 2 8 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 ff 2 03 1 0
13 01 02 03 ffffffffffff0000 2 4 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 fffffffffffff000 2 03 1 0
14 01 02 03 7fffffff 1 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 ffffffff80000000 1 03 1 0
15 01 02 03 100000000 1 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 ffffffffffffffff 1 03 1 0
16 01 02 03 1 1f 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 ffffffff80000000 1f 03 1 0
17 01 02 03 ffffffff80000000 4 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 8000000 4 03 1 0
18 01 02 03 80000000 4 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 fffffffff8000000 4 03 1 0
19 01 02 03 ffffffff 2 1 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 0 2 03 1 0
1a 01 02 03 1 2 1e 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 40000000 2 03 1 0
1b 01 02 03 f0 2 24 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 f 2 03 1 0
1c 01 02 03 80000000 2 1f 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 ffffffffffffffff 2 03 1 0
1d 01 02 03 5 2 12345000 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 12345000 2 03 1 0
1e 01 02 03 1000 2 8 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 1008 2 03 0 1
1f 01 02 03 2000 55 10 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 2010 55 03 0 0
3f 01 02 03 5 6 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 0 0 0 6 03 0 0
01 01 02 04 5 1 0 01 01 01 aaaa bbbb cccc dddd 0 1 0 0 aaab 1 04 1 0
01 01 02 04 5 1 0 1d 01 01 aaaa bbbb cccc dddd 0 1 0 0 bbbc 1 04 1 0
01 01 02 04 5 1 0 1d 01 01 aaaa bbbb cccc dddd 0 0 0 0 cccd 1 04 1 0
01 01 02 04 5 1 0 1d 1e 02 aaaa bbbb cccc dddd 0 0 0 0 dde2 dddd 04 1 0
01 01 02 05 5 1 0 01 1e 1f aaaa bbbb cccc dddd 1 0 0 1 bbbc 1 05 1 0
01 01 02 05 5 1 0 02 1e 1f aaaa bbbb cccc dddd 1 0 0 1 bbc0 bbbb 05 1 0
01 01 02 06 5 1 0 1d 1e 1f aaaa bbbb cccc dddd 0 0 1 0 0 0 00 0 0
01 00 02 07 5 1 0 00 1e 1f aaaa bbbb cccc dddd 0 0 0 0 aaab 1 07 1 0

/* files.f */
common/ex_pkg.sv
common/ex_operand_if.sv
rtl/ex_alu/ex_shift_unit.sv
rtl/ex_alu/ex_alu_stage.sv
rtl/ex_forward_unit.sv
rtl/execute_stage.sv
test/execute_stage_checker.sv
test/execute_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module execute_stage_tb \
    -f files.f -o execute_sim || exit 1
out=$(./obj_dir/execute_sim)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1

/* test/execute_stage_tb.sv */
// Data-file driven testbench for the execute stage; run from the project root
// Rows hold held inputs and expected outputs; idle gaps come from an LFSR
`timescale 1ns/1ns
`default_nettype none

module execute_stage_tb;
    import ex_pkg::*;

    localparam int NF           = 23;
    localparam int MAX_ROWS     = 64;
    localparam int RESET_CYCLES = 8;
    localparam int MARGIN       = 20;

    // Column positions within a data row
    localparam int F_OP = 0, F_RS1 = 1, F_RS2 = 2, F_RD = 3;
    localparam int F_V1 = 4, F_V2 = 5, F_IMM = 6;
    localparam int F_ALURD = 7, F_MMRD = 8, F_WBRD = 9;
    localparam int F_ALURES = 10, F_MDATA = 11, F_MMALU = 12, F_WB = 13;
    localparam int F_ALULD = 14, F_MMLD = 15, F_BR = 16, F_STALL = 17;
    localparam int F_RES = 18, F_RS2O = 19, F_RDO = 20, F_UPD = 21, F_LD = 22;

    logic               clk;
    logic               reset;
    logic               in_enable;
    logic [XLEN-1:0]    rs1_value;
    logic [XLEN-1:0]    rs2_value;
    logic [XLEN-1:0]    imm_value;
    logic [REGNO_W-1:0] rd_regno;
    logic [REGNO_W-1:0] rs1_regno;
    logic [REGNO_W-1:0] rs2_regno;
    logic [OP_W-1:0]    opcode;
    logic [REGNO_W-1:0] alu_rd_regno;
    logic [REGNO_W-1:0] mm_rd_regno;
    logic [REGNO_W-1:0] wb_rd_regno;
    logic [XLEN-1:0]    alu_alu_result;
    logic [XLEN-1:0]    mm_mdata;
    logic [XLEN-1:0]    mm_alu_result;
    logic [XLEN-1:0]    wb_data;
    logic               branch_taken;
    logic               alu_mm_load;
    logic               mm_mm_load;
    logic [XLEN-1:0]    out_alu_result;
    logic [XLEN-1:0]    out_rs2_value;
    logic [REGNO_W-1:0] out_rd_regno;
    logic [OP_W-1:0]    out_opcode;
    logic               out_update_rd;
    logic               out_mm_load;
    logic               out_ready;

    logic [63:0] field_mem [0:NF*MAX_ROWS-1];
    logic [31:0] lfsr_state;
    int          row_count    = 0;
    int          cycle_count  = 0;
    int          cycle_limit  = 0;
    int          check_count  = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    execute_stage dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("The run timed out after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    endtask

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        check_count++;
        if (got !== exp)
        begin
            value_errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_regno(input logic [REGNO_W-1:0] got, input logic [REGNO_W-1:0] exp,
                               input string what);
        check_count++;
        if (got !== exp)
        begin
            value_errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_opcode(input logic [OP_W-1:0] got, input logic [OP_W-1:0] exp,
                                input string what);
        check_count++;
        if (got !== exp)
        begin
            value_errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            value_errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic load_rows(output logic ok);
        int          fd;
        int          code;
        int          n;
        string       line;
        logic [63:0] f [0:NF-1];
        ok = 1'b0;
        fd = $fopen("test/execute_testdata.txt", "r");
        if (fd == 0)
            $display("Could not open the test data file");
        else
        begin
            while (!$feof(fd))
            begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23)
                begin
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                        f[20], f[21], f[22]);
                    if (n != NF || row_count >= MAX_ROWS)
                    begin
                        other_errors++;
                        $display("A test data line could not be used: %s", line);
                    end
                    else
                    begin
                        for (int k = 0; k < NF; k++)
                            field_mem[row_count*NF+k] = f[k];
                        row_count++;
                    end
                end
            end
            $fclose(fd);
            ok = (row_count > 0);
            if (!ok)
                $display("The test data file holds no rows");
        end
    endtask

    task automatic drive_row(input int r);
        int b;
        b = r * NF;
        opcode         <= field_mem[b+F_OP][OP_W-1:0];
        rs1_regno      <= field_mem[b+F_RS1][REGNO_W-1:0];
        rs2_regno      <= field_mem[b+F_RS2][REGNO_W-1:0];
        rd_regno       <= field_mem[b+F_RD][REGNO_W-1:0];
        rs1_value      <= field_mem[b+F_V1];
        rs2_value      <= field_mem[b+F_V2];
        imm_value      <= field_mem[b+F_IMM];
        alu_rd_regno   <= field_mem[b+F_ALURD][REGNO_W-1:0];
        mm_rd_regno    <= field_mem[b+F_MMRD][REGNO_W-1:0];
        wb_rd_regno    <= field_mem[b+F_WBRD][REGNO_W-1:0];
        alu_alu_result <= field_mem[b+F_ALURES];
        mm_mdata       <= field_mem[b+F_MDATA];
        mm_alu_result  <= field_mem[b+F_MMALU];
        wb_data        <= field_mem[b+F_WB];
        alu_mm_load    <= field_mem[b+F_ALULD][0];
        mm_mm_load     <= field_mem[b+F_MMLD][0];
        branch_taken   <= field_mem[b+F_BR][0];
        in_enable      <= 1'b1;
    endtask

    task automatic check_outputs(input int r, input string when);
        int              b;
        logic [OP_W-1:0] exp_op;
        b = r * NF;
        // A flushed accept registers zeros, otherwise the opcode travels on
        if (field_mem[b+F_BR][0])
            exp_op = OP_NOP;
        else
            exp_op = field_mem[b+F_OP][OP_W-1:0];
        check_word(out_alu_result, field_mem[b+F_RES],
                   $sformatf("row %0d result %s", r, when));
        check_word(out_rs2_value, field_mem[b+F_RS2O],
                   $sformatf("row %0d rs2 value %s", r, when));
        check_regno(out_rd_regno, field_mem[b+F_RDO][REGNO_W-1:0],
                    $sformatf("row %0d rd %s", r, when));
        check_opcode(out_opcode, exp_op,
                     $sformatf("row %0d opcode %s", r, when));
        check_flag(out_update_rd, field_mem[b+F_UPD][0],
                   $sformatf("row %0d update_rd %s", r, when));
        check_flag(out_mm_load, field_mem[b+F_LD][0],
                   $sformatf("row %0d mm_load %s", r, when));
    endtask

    task automatic run_row(input int r);
        int   low_cycles;
        int   idle;
        logic b0;
        logic b1;
        low_cycles = 0;
        @(posedge clk);
        drive_row(r);
        @(negedge clk);
        while (!out_ready)
        begin
            low_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        in_enable <= 1'b0;
        check_flag(low_cycles != 0, field_mem[r*NF+F_STALL][0],
                   $sformatf("row %0d stall", r));
        if (low_cycles > 1)
        begin
            value_errors++;
            $display("error at %0t ns: row %0d out_ready low for %0d cycles",
                     $time, r, low_cycles);
        end
        @(negedge clk);
        check_outputs(r, "after accept");
        take_bit(b0);
        take_bit(b1);
        idle = 0;
        if (b0)
            idle += 1;
        if (b1)
            idle += 2;
        if (idle > 0)
        begin
            repeat (idle) @(posedge clk);
            @(negedge clk);
            check_outputs(r, "after idle");
        end
    endtask

    initial
    begin
        logic ok;
        reset          = 1'b1;
        in_enable      = 1'b0;
        rs1_value      = '0;
        rs2_value      = '0;
        imm_value      = '0;
        rd_regno       = '0;
        rs1_regno      = '0;
        rs2_regno      = '0;
        opcode         = OP_NOP;
        alu_rd_regno   = '0;
        mm_rd_regno    = '0;
        wb_rd_regno    = '0;
        alu_alu_result = '0;
        mm_mdata       = '0;
        mm_alu_result  = '0;
        wb_data        = '0;
        branch_taken   = 1'b0;
        alu_mm_load    = 1'b0;
        mm_mm_load     = 1'b0;
        lfsr_state     = 32'hfb88_f7c8;
        load_rows(ok);
        if (!ok)
        begin
            $display("TEST FAILED");
            $finish;
        end
        else
        begin
            cycle_limit = row_count * 6 + RESET_CYCLES + MARGIN;
            repeat (RESET_CYCLES) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            check_flag(out_update_rd, 1'b0, "update_rd after reset");
            check_flag(out_mm_load, 1'b0, "mm_load after reset");
            for (int r = 0; r < row_count; r++)
                run_row(r);
            repeat (2) @(posedge clk);
            $display("Rows: %0d, checks: %0d, value errors: %0d, other errors: %0d",
                     row_count, check_count, value_errors, other_errors);
            if (value_errors == 0 && other_errors == 0)
                $display("TEST PASSED");
            else
                $display("TEST FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/execute_stage_checker.sv */
// Protocol assertions bound onto the execute stage top level
// The stall rule assumes inputs are held while out_ready is low
`timescale 1ns/1ns
`default_nettype none

module execute_stage_checker (
    input wire logic                       clk,
    input wire logic                       reset,
    input wire logic                       in_enable,
    input wire logic                       branch_taken,
    input wire logic                       out_ready,
    input wire logic                       out_update_rd,
    input wire logic                       out_mm_load,
    input wire logic [ex_pkg::XLEN-1:0]    out_alu_result,
    input wire logic [ex_pkg::XLEN-1:0]    out_rs2_value,
    input wire logic [ex_pkg::REGNO_W-1:0] out_rd_regno,
    input wire logic [ex_pkg::OP_W-1:0]    out_opcode
);

    flags_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(out_update_rd && out_mm_load))
        else $error("out_update_rd and out_mm_load are both high");

    // A load-use bubble lasts a single cycle
    stall_single: assert property (@(posedge clk) disable iff (reset)
        (in_enable && !out_ready) |=> out_ready)
        else $error("out_ready stayed low for more than one cycle");

    flush_zero: assert property (@(posedge clk) disable iff (reset)
        (in_enable && out_ready && branch_taken) |=>
        (out_alu_result == '0 && out_rs2_value == '0 && out_rd_regno == '0
         && out_opcode == '0 && !out_update_rd && !out_mm_load))
        else $error("outputs not cleared after a flushed accept");

endmodule

bind execute_stage execute_stage_checker u_checker (
    .clk            (clk),
    .reset          (reset),
    .in_enable      (in_enable),
    .branch_taken   (branch_taken),
    .out_ready      (out_ready),
    .out_update_rd  (out_update_rd),
    .out_mm_load    (out_mm_load),
    .out_alu_result (out_alu_result),
    .out_rs2_value  (out_rs2_value),
    .out_rd_regno   (out_rd_regno),
    .out_opcode     (out_opcode)
);

`default_nettype wire

/* rtl/execute_stage.sv */
// RV64I execute stage without the M extension, branches or pc path
// Inputs must be held with in_enable high until out_ready is seen high
// out_ready drops for one cycle on a load-use hazard against the ALU stage
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       in_enable,
    input  wire logic [ex_pkg::XLEN-1:0]    rs1_value,
    input  wire logic [ex_pkg::XLEN-1:0]    rs2_value,
    input  wire logic [ex_pkg::XLEN-1:0]    imm_value,
    input  wire logic [ex_pkg::REGNO_W-1:0] rd_regno,
    input  wire logic [ex_pkg::REGNO_W-1:0] rs1_regno,
    input  wire logic [ex_pkg::REGNO_W-1:0] rs2_regno,
    input  wire logic [ex_pkg::OP_W-1:0]    opcode,
    input  wire logic [ex_pkg::REGNO_W-1:0] alu_rd_regno,
    input  wire logic [ex_pkg::REGNO_W-1:0] mm_rd_regno,
    input  wire logic [ex_pkg::REGNO_W-1:0] wb_rd_regno,
    input  wire logic [ex_pkg::XLEN-1:0]    alu_alu_result,
    input  wire logic [ex_pkg::XLEN-1:0]    mm_mdata,
    input  wire logic [ex_pkg::XLEN-1:0]    mm_alu_result,
    input  wire logic [ex_pkg::XLEN-1:0]    wb_data,
    input  wire logic                       branch_taken,
    input  wire logic                       alu_mm_load,
    input  wire logic                       mm_mm_load,
    output logic      [ex_pkg::XLEN-1:0]    out_alu_result,
    output logic      [ex_pkg::XLEN-1:0]    out_rs2_value,
    output logic      [ex_pkg::REGNO_W-1:0] out_rd_regno,
    output logic      [ex_pkg::OP_W-1:0]    out_opcode,
    output logic                            out_update_rd,
    output logic                            out_mm_load,
    output logic                            out_ready
);

    ex_operand_if ops ();

    ex_forward_unit u_forward (
        .clk            (clk),
        .reset          (reset),
        .in_enable      (in_enable),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .imm_value      (imm_value),
        .rd_regno       (rd_regno),
        .rs1_regno      (rs1_regno),
        .rs2_regno      (rs2_regno),
        .opcode         (opcode),
        .alu_rd_regno   (alu_rd_regno),
        .mm_rd_regno    (mm_rd_regno),
        .wb_rd_regno    (wb_rd_regno),
        .alu_alu_result (alu_alu_result),
        .mm_mdata       (mm_mdata),
        .mm_alu_result  (mm_alu_result),
        .wb_data        (wb_data),
        .alu_mm_load    (alu_mm_load),
        .mm_mm_load     (mm_mm_load),
        .branch_taken   (branch_taken),
        .out_ready      (out_ready),
        .ops            (ops.fwd)
    );

    ex_alu_stage u_alu (
        .clk            (clk),
        .reset          (reset),
        .ops            (ops.alu),
        .out_alu_result (out_alu_result),
        .out_rs2_value  (out_rs2_value),
        .out_rd_regno   (out_rd_regno),
        .out_opcode     (out_opcode),
        .out_update_rd  (out_update_rd),
        .out_mm_load    (out_mm_load)
    );

endmodule

`default_nettype wire

/* rtl/ex_forward_unit.sv */
// Operand bypass from the ALU, memory and writeback stages, in that priority
// x0 is forwarded like any other register; the stage above must not tag x0 writes
`timescale 1ns/1ns
`default_nettype none

module ex_forward_unit (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       in_enable,
    input  wire logic [ex_pkg::XLEN-1:0]    rs1_value,
    input  wire logic [ex_pkg::XLEN-1:0]    rs2_value,
    input  wire logic [ex_pkg::XLEN-1:0]    imm_value,
    input  wire logic [ex_pkg::REGNO_W-1:0] rd_regno,
    input  wire logic [ex_pkg::REGNO_W-1:0] rs1_regno,
    input  wire logic [ex_pkg::REGNO_W-1:0] rs2_regno,
    input  wire logic [ex_pkg::OP_W-1:0]    opcode,
    input  wire logic [ex_pkg::REGNO_W-1:0] alu_rd_regno,
    input  wire logic [ex_pkg::REGNO_W-1:0] mm_rd_regno,
    input  wire logic [ex_pkg::REGNO_W-1:0] wb_rd_regno,
    input  wire logic [ex_pkg::XLEN-1:0]    alu_alu_result,
    input  wire logic [ex_pkg::XLEN-1:0]    mm_mdata,
    input  wire logic [ex_pkg::XLEN-1:0]    mm_alu_result,
    input  wire logic [ex_pkg::XLEN-1:0]    wb_data,
    input  wire logic                       alu_mm_load,
    input  wire logic                       mm_mm_load,
    input  wire logic                       branch_taken,
    output logic                            out_ready,
    ex_operand_if.fwd                       ops
);
    import ex_pkg::*;

    logic stall_cnt;
    logic rs1_load_hit;
    logic rs2_load_hit;
    logic stall_req;
    logic accept;

    // Newest producer wins. A load still in the ALU stage delivers its data
    // through mm_mdata once it has moved on, i.e. after the stall cycle
    function automatic logic [XLEN-1:0] resolve(
        input logic [REGNO_W-1:0] regno,
        input logic [XLEN-1:0]    reg_value
    );
        logic [XLEN-1:0] v;
        if (regno == alu_rd_regno)
            v = alu_mm_load ? mm_mdata : alu_alu_result;
        else if (regno == mm_rd_regno)
            v = mm_mm_load ? mm_mdata : mm_alu_result;
        else if (regno == wb_rd_regno)
            v = wb_data;
        else
            v = reg_value;
        return v;
    endfunction

    assign rs1_load_hit = (rs1_regno == alu_rd_regno) && alu_mm_load;
    assign rs2_load_hit = (rs2_regno == alu_rd_regno) && alu_mm_load;
    assign stall_req    = (rs1_load_hit || rs2_load_hit) && !stall_cnt;
    assign out_ready    = !stall_req;
    assign accept       = in_enable && out_ready;

    always_comb
    begin
        ops.value1 = resolve(rs1_regno, rs1_value);
        ops.value2 = resolve(rs2_regno, rs2_value);
    end

    assign ops.imm    = imm_value;
    assign ops.op     = opcode;
    assign ops.rd     = rd_regno;
    assign ops.accept = accept;
    assign ops.flush  = branch_taken;

    // Counts the single bubble cycle of a load-use hazard
    always_ff @(posedge clk)
    begin
        if (reset)
            stall_cnt <= 1'b0;
        else if (accept)
            stall_cnt <= 1'b0;
        else if (in_enable && stall_req)
            stall_cnt <= 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/ex_alu/ex_alu_stage.sv */
// Integer result by opcode and the registered stage outputs
// Loads and stores return the address value1 + imm; unknown opcodes give zeros
`timescale 1ns/1ns
`default_nettype none

module ex_alu_stage (
    input  wire logic                       clk,
    input  wire logic                       reset,
    ex_operand_if.alu                       ops,
    output logic      [ex_pkg::XLEN-1:0]    out_alu_result,
    output logic      [ex_pkg::XLEN-1:0]    out_rs2_value,
    output logic      [ex_pkg::REGNO_W-1:0] out_rd_regno,
    output logic      [ex_pkg::OP_W-1:0]    out_opcode,
    output logic                            out_update_rd,
    output logic                            out_mm_load
);
    import ex_pkg::*;

    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [XLEN-1:0] shift_result;
    logic            shift_word;
    logic            shift_right;
    logic            shift_arith;
    logic [XLEN-1:0] n_result;
    logic            n_update_rd;
    logic            n_mm_load;

    always_comb
    begin
        case (ops.op)
            OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
            OP_SLLI, OP_SRLI, OP_SRAI, OP_ADDIW, OP_SLLIW, OP_SRLIW,
            OP_SRAIW, OP_LOAD, OP_STORE:
                operand_b = ops.imm;
            default:
                operand_b = ops.value2;
        endcase
    end

    assign sum  = ops.value1 + operand_b;
    assign diff = ops.value1 - operand_b;

    assign shift_word  = (ops.op == OP_SLLW) || (ops.op == OP_SRLW) || (ops.op == OP_SRAW)
                      || (ops.op == OP_SLLIW) || (ops.op == OP_SRLIW) || (ops.op == OP_SRAIW);
    assign shift_right = (ops.op == OP_SRL) || (ops.op == OP_SRA) || (ops.op == OP_SRLI)
                      || (ops.op == OP_SRAI) || (ops.op == OP_SRLW) || (ops.op == OP_SRAW)
                      || (ops.op == OP_SRLIW) || (ops.op == OP_SRAIW);
    assign shift_arith = (ops.op == OP_SRA) || (ops.op == OP_SRAI)
                      || (ops.op == OP_SRAW) || (ops.op == OP_SRAIW);

    ex_shift_unit u_shift (
        .value    (ops.value1),
        .shamt    (operand_b[SHAMT_W-1:0]),
        .is_word  (shift_word),
        .is_right (shift_right),
        .is_arith (shift_arith),
        .result   (shift_result)
    );

    always_comb
    begin
        n_result    = '0;
        n_update_rd = 1'b1;
        n_mm_load   = 1'b0;
        case (ops.op)
            OP_ADD, OP_ADDI:   n_result = sum;
            OP_SUB:            n_result = diff;
            OP_ADDW, OP_ADDIW: n_result = {{(XLEN-WORD_W){sum[WORD_W-1]}}, sum[WORD_W-1:0]};
            OP_SUBW:           n_result = {{(XLEN-WORD_W){diff[WORD_W-1]}}, diff[WORD_W-1:0]};
            OP_SLT, OP_SLTI:
                n_result = {{(XLEN-1){1'b0}}, $signed(ops.value1) < $signed(operand_b)};
            OP_SLTU, OP_SLTIU:
                n_result = {{(XLEN-1){1'b0}}, ops.value1 < operand_b};
            OP_XOR, OP_XORI:   n_result = ops.value1 ^ operand_b;
            OP_OR, OP_ORI:     n_result = ops.value1 | operand_b;
            OP_AND, OP_ANDI:   n_result = ops.value1 & operand_b;
            OP_SLL, OP_SRL, OP_SRA, OP_SLLI, OP_SRLI, OP_SRAI,
            OP_SLLW, OP_SRLW, OP_SRAW, OP_SLLIW, OP_SRLIW, OP_SRAIW:
                n_result = shift_result;
            OP_LUI:            n_result = ops.imm;
            OP_LOAD:
            begin
                n_result    = sum;
                n_update_rd = 1'b0;
                n_mm_load   = 1'b1;
            end
            // Store address; rs2 travels on as store data
            OP_STORE:
            begin
                n_result    = sum;
                n_update_rd = 1'b0;
            end
            default:           n_update_rd = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset || (ops.accept && ops.flush))
        begin
            out_alu_result <= '0;
            out_rs2_value  <= '0;
            out_rd_regno   <= '0;
            out_opcode     <= '0;
            out_update_rd  <= 1'b0;
            out_mm_load    <= 1'b0;
        end
        else if (ops.accept)
        begin
            out_alu_result <= n_result;
            out_rs2_value  <= ops.value2;
            out_rd_regno   <= ops.rd;
            out_opcode     <= ops.op;
            out_update_rd  <= n_update_rd;
            out_mm_load    <= n_mm_load;
        end
    end

endmodule

`default_nettype wire

/* rtl/ex_alu/ex_shift_unit.sv */
// Combinational shifter for 64-bit and word operands
// Word forms use only shamt[4:0] and sign-extend the 32-bit result
`timescale 1ns/1ns
`default_nettype none

module ex_shift_unit (
    input  wire logic [ex_pkg::XLEN-1:0]    value,
    input  wire logic [ex_pkg::SHAMT_W-1:0] shamt,
    input  wire logic                       is_word,
    input  wire logic                       is_right,
    input  wire logic                       is_arith,
    output logic      [ex_pkg::XLEN-1:0]    result
);
    import ex_pkg::*;

    logic [WORD_W-1:0]   word_in;
    logic [SHAMTW_W-1:0] word_amt;
    logic [WORD_W-1:0]   word_res;
    logic [XLEN-1:0]     full_res;

    assign word_in  = value[WORD_W-1:0];
    assign word_amt = shamt[SHAMTW_W-1:0];

    // Arithmetic cases kept apart so the signed shift is not made unsigned
    always_comb
    begin
        if (!is_right)
            word_res = word_in << word_amt;
        else if (is_arith)
            word_res = $signed(word_in) >>> word_amt;
        else
            word_res = word_in >> word_amt;

        if (!is_right)
            full_res = value << shamt;
        else if (is_arith)
            full_res = $signed(value) >>> shamt;
        else
            full_res = value >> shamt;
    end

    assign result = is_word ? {{(XLEN-WORD_W){word_res[WORD_W-1]}}, word_res} : full_res;

endmodule

`default_nettype wire

/* common/ex_operand_if.sv */
// Resolved operands and instruction fields from the forwarding logic to the ALU
// accept and flush are levels valid in the cycle they are driven
`timescale 1ns/1ns
`default_nettype none

interface ex_operand_if;
    import ex_pkg::*;

    logic [XLEN-1:0]    value1;
    logic [XLEN-1:0]    value2;
    logic [XLEN-1:0]    imm;
    logic [OP_W-1:0]    op;
    logic [REGNO_W-1:0] rd;
    logic               accept;
    logic               flush;

    modport fwd (
        output value1, value2, imm, op, rd, accept, flush
    );

    modport alu (
        input value1, value2, imm, op, rd, accept, flush
    );

endinterface

`default_nettype wire

/* common/ex_pkg.sv */
// Widths and opcode codes shared by the execute stage and its testbench
// Opcode codes are plain OP_W-bit numbers; any value not listed acts as a NOP
`default_nettype none

package ex_pkg;

    localparam int XLEN     = 64;
    localparam int WORD_W   = 32;
    localparam int REGNO_W  = 5;
    localparam int OP_W     = 6;
    localparam int SHAMT_W  = 6;
    localparam int SHAMTW_W = 5;

    localparam logic [OP_W-1:0] OP_NOP   = 6'd0;

    // Register forms
    localparam logic [OP_W-1:0] OP_ADD   = 6'd1;
    localparam logic [OP_W-1:0] OP_SUB   = 6'd2;
    localparam logic [OP_W-1:0] OP_SLL   = 6'd3;
    localparam logic [OP_W-1:0] OP_SLT   = 6'd4;
    localparam logic [OP_W-1:0] OP_SLTU  = 6'd5;
    localparam logic [OP_W-1:0] OP_XOR   = 6'd6;
    localparam logic [OP_W-1:0] OP_SRL   = 6'd7;
    localparam logic [OP_W-1:0] OP_SRA   = 6'd8;
    localparam logic [OP_W-1:0] OP_OR    = 6'd9;
    localparam logic [OP_W-1:0] OP_AND   = 6'd10;

    // Immediate forms
    localparam logic [OP_W-1:0] OP_ADDI  = 6'd11;
    localparam logic [OP_W-1:0] OP_SLTI  = 6'd12;
    localparam logic [OP_W-1:0] OP_SLTIU = 6'd13;
    localparam logic [OP_W-1:0] OP_XORI  = 6'd14;
    localparam logic [OP_W-1:0] OP_ORI   = 6'd15;
    localparam logic [OP_W-1:0] OP_ANDI  = 6'd16;
    localparam logic [OP_W-1:0] OP_SLLI  = 6'd17;
    localparam logic [OP_W-1:0] OP_SRLI  = 6'd18;
    localparam logic [OP_W-1:0] OP_SRAI  = 6'd19;

    // Word forms, results sign-extended from bit 31
    localparam logic [OP_W-1:0] OP_ADDW  = 6'd20;
    localparam logic [OP_W-1:0] OP_SUBW  = 6'd21;
    localparam logic [OP_W-1:0] OP_SLLW  = 6'd22;
    localparam logic [OP_W-1:0] OP_SRLW  = 6'd23;
    localparam logic [OP_W-1:0] OP_SRAW  = 6'd24;
    localparam logic [OP_W-1:0] OP_ADDIW = 6'd25;
    localparam logic [OP_W-1:0] OP_SLLIW = 6'd26;
    localparam logic [OP_W-1:0] OP_SRLIW = 6'd27;
    localparam logic [OP_W-1:0] OP_SRAIW = 6'd28;

    localparam logic [OP_W-1:0] OP_LUI   = 6'd29;
    localparam logic [OP_W-1:0] OP_LOAD  = 6'd30;
    localparam logic [OP_W-1:0] OP_STORE = 6'd31;

endpackage

`default_nettype wire
